//--- Bender.yml
package:
  name: soc_bus

sources:
  - rtl/soc_bus_pkg.sv
  - rtl/soc_map_pkg.sv
  - rtl/dbus.sv
  - rtl/data_ram.sv
  - rtl/gpio_top.sv
  - rtl/uart_tx.sv
  - rtl/soc_bus_top.sv
  - target: simulation
    files:
      - tb/bus_checker.sv
      - tb/tb_soc_bus.sv

//--- all.f
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/dbus.sv
rtl/data_ram.sv
rtl/gpio_top.sv
rtl/uart_tx.sv
rtl/soc_bus_top.sv
tb/bus_checker.sv
tb/tb_soc_bus.sv

//--- rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                  clk,
    input  soc_bus_pkg::ram_idx_t ram_address_i,
    input  soc_bus_pkg::data_t    ram_wrdata_i,
    input  soc_bus_pkg::be_t      ram_byteenable_i,
    input  logic                  ram_read_i,
    input  logic                  ram_write_i,
    output soc_bus_pkg::data_t    ram_rddata_o
);

    soc_bus_pkg::data_t mem [soc_bus_pkg::RAM_WORDS];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        if (ram_write_i) begin
            for (int i = 0; i < soc_bus_pkg::BE_W; i++) begin
                if (ram_byteenable_i[i]) begin
                    mem[ram_address_i][8*i +: 8] <= ram_wrdata_i[8*i +: 8];
                end
            end
        end
    end

    // registered read, holds between reads
    always_ff @(posedge clk) begin
        if (ram_read_i) begin
            ram_rddata_o <= mem[ram_address_i];
        end
    end

    a_addr_known: assert property (@(posedge clk)
        (ram_read_i || ram_write_i) |-> !$isunknown(ram_address_i));

endmodule

//--- rtl/dbus.sv
`timescale 1ns/1ps

module dbus (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  soc_bus_pkg::addr_t     master_address_i,
    input  soc_bus_pkg::be_t       master_byteenable_i,
    input  logic                   master_read_i,
    input  logic                   master_write_i,
    input  soc_bus_pkg::data_t     master_wrdata_i,
    output soc_bus_pkg::data_t     master_rddata_o,
    output soc_bus_pkg::ram_idx_t  ram_address_o,
    output soc_bus_pkg::data_t     ram_wrdata_o,
    output soc_bus_pkg::be_t       ram_byteenable_o,
    output logic                   ram_read_o,
    output logic                   ram_write_o,
    input  soc_bus_pkg::data_t     ram_rddata_i,
    output soc_bus_pkg::gpio_ofs_t gpio_address_o,
    output soc_bus_pkg::data_t     gpio_wrdata_o,
    output soc_bus_pkg::be_t       gpio_byteenable_o,
    output logic                   gpio_read_o,
    output logic                   gpio_write_o,
    input  soc_bus_pkg::data_t     gpio_rddata_i,
    output soc_bus_pkg::uart_ofs_t uart_address_o,
    output soc_bus_pkg::data_t     uart_wrdata_o,
    output logic                   uart_read_o,
    output logic                   uart_write_o,
    input  soc_bus_pkg::data_t     uart_rddata_i
);

    soc_bus_pkg::slave_sel_e sel;
    soc_bus_pkg::slave_sel_e rd_sel_q;
    logic ram_hit;
    logic gpio_hit;
    logic uart_hit;

    // window match on the upper address bits
    assign ram_hit = master_address_i[31:soc_map_pkg::RAM_OFS_W] ==
                     soc_map_pkg::RAM_BASE[31:soc_map_pkg::RAM_OFS_W];
    assign gpio_hit = master_address_i[31:soc_map_pkg::GPIO_OFS_W] ==
                      soc_map_pkg::GPIO_BASE[31:soc_map_pkg::GPIO_OFS_W];
    assign uart_hit = master_address_i[31:soc_map_pkg::UART_OFS_W] ==
                      soc_map_pkg::UART_BASE[31:soc_map_pkg::UART_OFS_W];

    always_comb begin
        sel = soc_bus_pkg::SEL_NONE;
        if (ram_hit) begin
            sel = soc_bus_pkg::SEL_RAM;
        end else if (gpio_hit) begin
            sel = soc_bus_pkg::SEL_GPIO;
        end else if (uart_hit) begin
            sel = soc_bus_pkg::SEL_UART;
        end
    end

    // RAM takes a word index
    assign ram_address_o    = master_address_i[soc_map_pkg::RAM_OFS_W-1:2];
    assign ram_wrdata_o     = master_wrdata_i;
    assign ram_byteenable_o = master_byteenable_i;
    assign ram_read_o       = master_read_i && ram_hit;
    assign ram_write_o      = master_write_i && ram_hit;

    assign gpio_address_o    = master_address_i[soc_map_pkg::GPIO_OFS_W-1:0];
    assign gpio_wrdata_o     = master_wrdata_i;
    assign gpio_byteenable_o = master_byteenable_i;
    assign gpio_read_o       = master_read_i && gpio_hit;
    assign gpio_write_o      = master_write_i && gpio_hit;

    assign uart_address_o = master_address_i[soc_map_pkg::UART_OFS_W-1:0];
    assign uart_wrdata_o  = master_wrdata_i;
    assign uart_read_o    = master_read_i && uart_hit;
    assign uart_write_o   = master_write_i && uart_hit;

    // owner of last cycle's read or none
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_sel_q <= soc_bus_pkg::SEL_NONE;
        end else if (master_read_i) begin
            rd_sel_q <= sel;
        end else begin
            rd_sel_q <= soc_bus_pkg::SEL_NONE;
        end
    end

    always_comb begin
        unique case (rd_sel_q)
            soc_bus_pkg::SEL_RAM:  master_rddata_o = ram_rddata_i;
            soc_bus_pkg::SEL_GPIO: master_rddata_o = gpio_rddata_i;
            soc_bus_pkg::SEL_UART: master_rddata_o = uart_rddata_i;
            default:               master_rddata_o = '0;
        endcase
    end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(master_read_i && master_write_i));

    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({ram_read_o | ram_write_o, gpio_read_o | gpio_write_o,
                  uart_read_o | uart_write_o}));

endmodule

//--- rtl/gpio_top.sv
`timescale 1ns/1ps

module gpio_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  soc_bus_pkg::gpio_ofs_t gpio_address_i,
    input  soc_bus_pkg::data_t     gpio_wrdata_i,
    input  soc_bus_pkg::be_t       gpio_byteenable_i,
    input  logic                   gpio_read_i,
    input  logic                   gpio_write_i,
    output soc_bus_pkg::data_t     gpio_rddata_o,
    input  soc_bus_pkg::data_t     gpio1_i,
    output soc_bus_pkg::data_t     gpio0_o
);

    soc_bus_pkg::data_t out_q;
    soc_bus_pkg::data_t sync1_q;
    soc_bus_pkg::data_t sync2_q;
    logic out_wr;

    assign out_wr = gpio_write_i && (gpio_address_i == soc_map_pkg::GPIO_OUT_OFS);

    // output port, byte-wise update
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (out_wr) begin
            for (int i = 0; i < soc_bus_pkg::BE_W; i++) begin
                if (gpio_byteenable_i[i]) begin
                    out_q[8*i +: 8] <= gpio_wrdata_i[8*i +: 8];
                end
            end
        end
    end

    assign gpio0_o = out_q;

    // two-flop synchronizer on the input pins
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio1_i;
            sync2_q <= sync1_q;
        end
    end

    // input register is read-only, so writes to it fall through
    always_ff @(posedge clk) begin
        if (gpio_read_i) begin
            case (gpio_address_i)
                soc_map_pkg::GPIO_OUT_OFS: gpio_rddata_o <= out_q;
                soc_map_pkg::GPIO_IN_OFS:  gpio_rddata_o <= sync2_q;
                default:                   gpio_rddata_o <= '0;
            endcase
        end
    end

endmodule

//--- rtl/soc_bus_pkg.sv
package soc_bus_pkg;

    // data bus of the CPU side, byte addressed
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    // on-chip data RAM depth in words
    localparam int unsigned RAM_WORDS = 1024;
    localparam int unsigned RAM_AW    = $clog2(RAM_WORDS);

    // offset widths inside the peripheral windows
    localparam int unsigned GPIO_AW = 8;
    localparam int unsigned UART_AW = 4;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [BE_W-1:0]    be_t;
    typedef logic [RAM_AW-1:0]  ram_idx_t;
    typedef logic [GPIO_AW-1:0] gpio_ofs_t;
    typedef logic [UART_AW-1:0] uart_ofs_t;

    // owner of the current access
    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_RAM,
        SEL_GPIO,
        SEL_UART
    } slave_sel_e;

endpackage

//--- rtl/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  soc_bus_pkg::addr_t master_address_i,
    input  soc_bus_pkg::be_t   master_byteenable_i,
    input  logic               master_read_i,
    input  logic               master_write_i,
    input  soc_bus_pkg::data_t master_wrdata_i,
    output soc_bus_pkg::data_t master_rddata_o,
    input  soc_bus_pkg::data_t gpio1_i,
    output soc_bus_pkg::data_t gpio0_o,
    output logic               txd_o
);

    // RAM side
    soc_bus_pkg::ram_idx_t ram_address;
    soc_bus_pkg::data_t    ram_wrdata;
    soc_bus_pkg::be_t      ram_byteenable;
    logic                  ram_read;
    logic                  ram_write;
    soc_bus_pkg::data_t    ram_rddata;

    // GPIO side
    soc_bus_pkg::gpio_ofs_t gpio_address;
    soc_bus_pkg::data_t     gpio_wrdata;
    soc_bus_pkg::be_t       gpio_byteenable;
    logic                   gpio_read;
    logic                   gpio_write;
    soc_bus_pkg::data_t     gpio_rddata;

    // UART side
    soc_bus_pkg::uart_ofs_t uart_address;
    soc_bus_pkg::data_t     uart_wrdata;
    logic                   uart_read;
    logic                   uart_write;
    soc_bus_pkg::data_t     uart_rddata;

    dbus dbus0 (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .master_address_i    (master_address_i),
        .master_byteenable_i (master_byteenable_i),
        .master_read_i       (master_read_i),
        .master_write_i      (master_write_i),
        .master_wrdata_i     (master_wrdata_i),
        .master_rddata_o     (master_rddata_o),
        .ram_address_o       (ram_address),
        .ram_wrdata_o        (ram_wrdata),
        .ram_byteenable_o    (ram_byteenable),
        .ram_read_o          (ram_read),
        .ram_write_o         (ram_write),
        .ram_rddata_i        (ram_rddata),
        .gpio_address_o      (gpio_address),
        .gpio_wrdata_o       (gpio_wrdata),
        .gpio_byteenable_o   (gpio_byteenable),
        .gpio_read_o         (gpio_read),
        .gpio_write_o        (gpio_write),
        .gpio_rddata_i       (gpio_rddata),
        .uart_address_o      (uart_address),
        .uart_wrdata_o       (uart_wrdata),
        .uart_read_o         (uart_read),
        .uart_write_o        (uart_write),
        .uart_rddata_i       (uart_rddata)
    );

    data_ram ram0 (
        .clk              (clk),
        .ram_address_i    (ram_address),
        .ram_wrdata_i     (ram_wrdata),
        .ram_byteenable_i (ram_byteenable),
        .ram_read_i       (ram_read),
        .ram_write_i      (ram_write),
        .ram_rddata_o     (ram_rddata)
    );

    gpio_top gpio0 (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .gpio_address_i    (gpio_address),
        .gpio_wrdata_i     (gpio_wrdata),
        .gpio_byteenable_i (gpio_byteenable),
        .gpio_read_i       (gpio_read),
        .gpio_write_i      (gpio_write),
        .gpio_rddata_o     (gpio_rddata),
        .gpio1_i           (gpio1_i),
        .gpio0_o           (gpio0_o)
    );

    uart_tx uart0 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .uart_address_i (uart_address),
        .uart_wrdata_i  (uart_wrdata),
        .uart_read_i    (uart_read),
        .uart_write_i   (uart_write),
        .uart_rddata_o  (uart_rddata),
        .txd_o          (txd_o)
    );

endmodule

//--- rtl/soc_map_pkg.sv
package soc_map_pkg;

    // kseg0 data RAM, 4 KiB
    localparam logic [31:0] RAM_BASE = 32'h8000_0000;
    localparam int unsigned RAM_SIZE = 4096;

    // kseg1 peripherals
    localparam logic [31:0] GPIO_BASE = 32'hBFD0_F000;
    localparam int unsigned GPIO_SIZE = 256;
    localparam logic [31:0] UART_BASE = 32'hBFD0_03F0;
    localparam int unsigned UART_SIZE = 16;

    // gpio registers
    localparam logic [7:0] GPIO_OUT_OFS = 8'h00;
    localparam logic [7:0] GPIO_IN_OFS  = 8'h04;

    // uart registers
    localparam logic [3:0] UART_DATA_OFS = 4'h0;
    localparam logic [3:0] UART_STAT_OFS = 4'h4;

    // clock cycles per serial bit
    localparam int unsigned UART_DIVISOR = 16;
    localparam int unsigned UART_BAUD_W  = $clog2(UART_DIVISOR);
    localparam logic [UART_BAUD_W-1:0] UART_BAUD_LAST = UART_BAUD_W'(UART_DIVISOR - 1);

    // low address bits that index inside each window
    localparam int unsigned RAM_OFS_W  = $clog2(RAM_SIZE);
    localparam int unsigned GPIO_OFS_W = $clog2(GPIO_SIZE);
    localparam int unsigned UART_OFS_W = $clog2(UART_SIZE);

endpackage

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  soc_bus_pkg::uart_ofs_t uart_address_i,
    input  soc_bus_pkg::data_t     uart_wrdata_i,
    input  logic                   uart_read_i,
    input  logic                   uart_write_i,
    output soc_bus_pkg::data_t     uart_rddata_o,
    output logic                   txd_o
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_e;

    tx_state_e state_q;
    logic [soc_map_pkg::UART_BAUD_W-1:0] baud_cnt_q;
    logic [2:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic txd_q;
    logic baud_done;
    logic start_req;

    assign baud_done = baud_cnt_q == soc_map_pkg::UART_BAUD_LAST;
    // busy writes are dropped here
    assign start_req = uart_write_i && (uart_address_i == soc_map_pkg::UART_DATA_OFS) &&
                       (state_q == IDLE);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            shift_q    <= '0;
            txd_q      <= 1'b1;
        end else begin
            baud_cnt_q <= (state_q == IDLE || baud_done) ? '0 : baud_cnt_q + 1'b1;
            case (state_q)
                IDLE: begin
                    if (start_req) begin
                        shift_q <= uart_wrdata_i[7:0];
                        txd_q   <= 1'b0;
                        state_q <= START;
                    end
                end
                START: begin
                    if (baud_done) begin
                        txd_q     <= shift_q[0];
                        bit_cnt_q <= '0;
                        state_q   <= DATA;
                    end
                end
                DATA: begin
                    if (baud_done) begin
                        if (bit_cnt_q == 3'd7) begin
                            txd_q   <= 1'b1;
                            state_q <= STOP;
                        end else begin
                            // lsb first
                            txd_q     <= shift_q[1];
                            shift_q   <= shift_q >> 1;
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                STOP: begin
                    if (baud_done) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign txd_o = txd_q;

    // STAT bit 0 is idle, DATA reads zero without a receiver
    always_ff @(posedge clk) begin
        if (uart_read_i) begin
            if (uart_address_i == soc_map_pkg::UART_STAT_OFS) begin
                uart_rddata_o <= {31'b0, state_q == IDLE};
            end else begin
                uart_rddata_o <= '0;
            end
        end
    end

    a_idle_mark: assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_q == IDLE) |-> txd_o);

endmodule

//--- tb/bus_checker.sv
`timescale 1ns/1ps

module bus_checker (
    input  logic               clk,
    input  logic               rst_n_i,
    input  soc_bus_pkg::addr_t master_address_i,
    input  soc_bus_pkg::be_t   master_byteenable_i,
    input  logic               master_read_i,
    input  logic               master_write_i,
    input  soc_bus_pkg::data_t master_wrdata_i,
    input  soc_bus_pkg::data_t master_rddata_i,
    input  soc_bus_pkg::data_t gpio0_i,
    input  logic               txd_i,
    input  soc_bus_pkg::data_t exp_rddata_i,
    output int                 read_errors_o,
    output int                 gpio_errors_o,
    output int                 uart_errors_o,
    output int                 frames_left_o
);

    localparam int unsigned FRAME_CYCLES = 10 * soc_map_pkg::UART_DIVISOR;

    logic               rd_pend_q;
    soc_bus_pkg::addr_t rd_addr_q;
    soc_bus_pkg::data_t rd_exp_q;
    logic               gpio_pend_q;
    soc_bus_pkg::data_t gpio_model_q;
    int unsigned        tx_busy_q;
    logic [7:0]         tx_bytes[$];
    int                 tx_queued = 0;
    int                 tx_seen = 0;
    int                 read_errs = 0;
    int                 gpio_errs = 0;
    int                 uart_errs = 0;
    logic               gpio_out_wr;
    logic               uart_data_wr;

    assign gpio_out_wr  = master_write_i &&
        (master_address_i == soc_map_pkg::GPIO_BASE + soc_map_pkg::GPIO_OUT_OFS);
    assign uart_data_wr = master_write_i &&
        (master_address_i == soc_map_pkg::UART_BASE + soc_map_pkg::UART_DATA_OFS);

    assign read_errors_o = read_errs;
    assign gpio_errors_o = gpio_errs;
    assign uart_errors_o = uart_errs;
    assign frames_left_o = tx_queued - tx_seen;

    // bus inputs are stable at the rising edge
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_pend_q    <= 1'b0;
            gpio_pend_q  <= 1'b0;
            gpio_model_q <= '0;
            tx_busy_q    <= 0;
        end else begin
            rd_pend_q   <= master_read_i;
            rd_addr_q   <= master_address_i;
            rd_exp_q    <= exp_rddata_i;
            gpio_pend_q <= gpio_out_wr;
            if (gpio_out_wr) begin
                for (int i = 0; i < 4; i++) begin
                    if (master_byteenable_i[i]) begin
                        gpio_model_q[8*i +: 8] <= master_wrdata_i[8*i +: 8];
                    end
                end
            end
            // transmitter model, busy for one whole frame
            if (uart_data_wr && tx_busy_q == 0) begin
                tx_bytes.push_back(master_wrdata_i[7:0]);
                tx_queued <= tx_queued + 1;
                tx_busy_q <= FRAME_CYCLES;
            end else if (tx_busy_q != 0) begin
                tx_busy_q <= tx_busy_q - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n_i && rd_pend_q && master_rddata_i !== rd_exp_q) begin
            read_errs++;
            $display("FAILED master_rddata_o (addr 0x%08h): expected 0x%08h got 0x%08h",
                     rd_addr_q, rd_exp_q, master_rddata_i);
        end
        if (rst_n_i && gpio_pend_q && gpio0_i !== gpio_model_q) begin
            gpio_errs++;
            $display("FAILED gpio0_o: expected 0x%08h got 0x%08h", gpio_model_q, gpio0_i);
        end
    end

    // frames as {stop, data, start}, sampled mid-bit
    initial begin : frame_watch
        logic [9:0] got;
        logic [9:0] want;
        logic [7:0] byte_exp;
        forever begin
            @(negedge clk);
            if (rst_n_i && txd_i === 1'b0) begin
                repeat (soc_map_pkg::UART_DIVISOR / 2) @(negedge clk);
                for (int i = 0; i < 10; i++) begin
                    got[i] = txd_i;
                    if (i < 9) begin
                        repeat (soc_map_pkg::UART_DIVISOR) @(negedge clk);
                    end
                end
                if (tx_bytes.size() == 0) begin
                    uart_errs++;
                    $display("txd_o sent frame 0x%03h with no accepted UART write", got);
                end else begin
                    byte_exp = tx_bytes.pop_front();
                    want     = {1'b1, byte_exp, 1'b0};
                    tx_seen  = tx_seen + 1;
                    if (got !== want) begin
                        uart_errs++;
                        $display("FAILED txd_o frame: expected 0x%03h got 0x%03h", want, got);
                    end
                end
            end
        end
    end

endmodule

//--- tb/bus_vectors.txt
# op addr be data exp, all hex; D waits data extra idle cycles, P drives next random gpio1_i
# GPIO_IN reads check the last value driven on gpio1_i, their exp column is unused
R bfd003f4 f 00000000 00000001
R 00001000 f 00000000 00000000
W 80000000 f 11223344 00000000
W 80000004 f aabbccdd 00000000
W 80000ffc f cafef00d 00000000
W 80000000 5 ffeeddcc 00000000
W 80000004 a 12345678 00000000
W 80000ffc 1 000000ff 00000000
R 80000000 f 00000000 11ee33cc
R 80000004 f 00000000 12bb56dd
R 80000ffc f 00000000 cafef0ff
W 80001000 f deadbeef 00000000
W 00000000 f 55555555 00000000
R 80001000 f 00000000 00000000
R 00000000 f 00000000 00000000
R 80000000 f 00000000 11ee33cc
W bfd0f000 f a5a5a5a5 00000000
R bfd0f000 f 00000000 a5a5a5a5
W bfd0f000 6 12345678 00000000
R bfd0f000 f 00000000 a53456a5
W bfd0f004 f ffffffff 00000000
R bfd0f000 f 00000000 a53456a5
R bfd0f008 f 00000000 00000000
P 00000000 0 00000000 00000000
D 00000000 0 00000003 00000000
R bfd0f004 f 00000000 00000000
P 00000000 0 00000000 00000000
D 00000000 0 00000003 00000000
R bfd0f004 f 00000000 00000000
W bfd003f0 1 000000a5 00000000
R bfd003f4 f 00000000 00000000
R bfd003f0 f 00000000 00000000
D 00000000 0 000000aa 00000000
R bfd003f4 f 00000000 00000001
W bfd003f0 1 0000003c 00000000
D 00000000 0 00000014 00000000
W bfd003f0 1 000000ff 00000000
R bfd003f4 f 00000000 00000000
D 00000000 0 000000c8 00000000
R bfd003f4 f 00000000 00000001

//--- tb/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;

    typedef struct packed {
        logic [7:0]         op;
        soc_bus_pkg::addr_t addr;
        soc_bus_pkg::be_t   be;
        soc_bus_pkg::data_t data;
        soc_bus_pkg::data_t exp;
    } vector_t;

    logic               clk;
    logic               rst_n;
    soc_bus_pkg::addr_t master_address;
    soc_bus_pkg::be_t   master_byteenable;
    logic               master_read;
    logic               master_write;
    soc_bus_pkg::data_t master_wrdata;
    soc_bus_pkg::data_t master_rddata;
    soc_bus_pkg::data_t gpio1;
    soc_bus_pkg::data_t gpio0;
    logic               txd;
    soc_bus_pkg::data_t exp_rddata;

    vector_t     vectors[$];
    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;
    logic [31:0] rand_state = 32'h56f713d9;
    int          other_errors = 0;
    int          read_errors;
    int          gpio_errors;
    int          uart_errors;
    int          frames_left;

    soc_bus_top DUT (
        .clk                 (clk),
        .rst_n_i             (rst_n),
        .master_address_i    (master_address),
        .master_byteenable_i (master_byteenable),
        .master_read_i       (master_read),
        .master_write_i      (master_write),
        .master_wrdata_i     (master_wrdata),
        .master_rddata_o     (master_rddata),
        .gpio1_i             (gpio1),
        .gpio0_o             (gpio0),
        .txd_o               (txd)
    );

    bus_checker checker0 (
        .clk                 (clk),
        .rst_n_i             (rst_n),
        .master_address_i    (master_address),
        .master_byteenable_i (master_byteenable),
        .master_read_i       (master_read),
        .master_write_i      (master_write),
        .master_wrdata_i     (master_wrdata),
        .master_rddata_i     (master_rddata),
        .gpio0_i             (gpio0),
        .txd_i               (txd),
        .exp_rddata_i        (exp_rddata),
        .read_errors_o       (read_errors),
        .gpio_errors_o       (gpio_errors),
        .uart_errors_o       (uart_errors),
        .frames_left_o       (frames_left)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic load_vectors();
        int                 fd;
        int                 n;
        string              line;
        logic [7:0]         op;
        soc_bus_pkg::addr_t addr;
        soc_bus_pkg::be_t   be;
        soc_bus_pkg::data_t data;
        soc_bus_pkg::data_t exp;
        fd = $fopen("tb/bus_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/bus_vectors.txt, no vectors run");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%c %h %h %h %h", op, addr, be, data, exp);
                // comment and blank lines fall out here
                if (n == 5 && (op == "W" || op == "R" || op == "P" || op == "D")) begin
                    vectors.push_back('{op, addr, be, data, exp});
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic release_bus();
        master_read  = 1'b0;
        master_write = 1'b0;
    endtask

    // one bus cycle per vector, D adds its idle cycles
    task automatic run_vector(input vector_t v);
        @(negedge clk);
        release_bus();
        case (v.op)
            "W": begin
                master_address    = v.addr;
                master_byteenable = v.be;
                master_wrdata     = v.data;
                master_write      = 1'b1;
            end
            "R": begin
                master_address    = v.addr;
                master_byteenable = v.be;
                master_read       = 1'b1;
                // input port reads back what the pins carry
                if (v.addr == soc_map_pkg::GPIO_BASE + soc_map_pkg::GPIO_IN_OFS) begin
                    exp_rddata = gpio1;
                end else begin
                    exp_rddata = v.exp;
                end
            end
            "P": begin
                rand_state = xorshift32(rand_state);
                gpio1      = rand_state;
            end
            default: begin
                repeat (v.data) @(negedge clk);
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: vectors still running after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rst_n             = 1'b0;
        master_address    = '0;
        master_byteenable = '0;
        master_read       = 1'b0;
        master_write      = 1'b0;
        master_wrdata     = '0;
        gpio1             = '0;
        exp_rddata        = '0;
        load_vectors();
        cycle_limit = vectors.size() * 200 + 1000;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (vectors[i]) begin
            run_vector(vectors[i]);
        end
        @(negedge clk);
        release_bus();
        repeat (4) @(negedge clk);
        if (frames_left != 0) begin
            $display("%0d accepted UART byte(s) never appeared on txd_o", frames_left);
            other_errors++;
        end
        $display("errors: read %0d, gpio %0d, uart %0d, other %0d",
                 read_errors, gpio_errors, uart_errors, other_errors);
        if (read_errors + gpio_errors + uart_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
